/* src.f */
+incdir+hdl
hdl/hello_world_pkg.sv
hdl/reg_access_if.sv
hdl/ocl_slave.sv
hdl/hello_regs.sv
hdl/vled_output.sv
hdl/cl_hello_world.sv
verification/cl_hello_world_assertions.sv
verification/tb_cl_hello_world.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the fail message in the log
verilator --binary --timing --assert -f src.f --top-module tb_cl_hello_world \
  -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || \
  { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Result: fail"; exit 1; } || echo "Result: pass"

/* verification/tb_cl_hello_world.sv */
`include "hello_world_defines.svh"

module tb_cl_hello_world;

  logic                       clk_main_a0;
  logic                       rst_main_n_sync;
  logic                       sh_ocl_awvalid;
  hello_world_pkg::ocl_addr_t sh_ocl_awaddr;
  logic                       sh_ocl_wvalid;
  hello_world_pkg::ocl_data_t sh_ocl_wdata;
  logic                       sh_ocl_bready;
  logic                       sh_ocl_arvalid;
  hello_world_pkg::ocl_addr_t sh_ocl_araddr;
  logic                       sh_ocl_rready;
  hello_world_pkg::vled_t     sh_cl_status_vdip;
  logic                       ocl_sh_awready;
  logic                       ocl_sh_wready;
  logic                       ocl_sh_bvalid;
  logic                       ocl_sh_arready;
  logic                       ocl_sh_rvalid;
  hello_world_pkg::ocl_data_t ocl_sh_rdata;
  hello_world_pkg::vled_t     cl_sh_status_vled;

  integer                     seed;
  int unsigned                tests_run;
  int unsigned                tests_failed;
  int unsigned                fails_before;

  cl_hello_world dut_i (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;
  end

  // 5 tests, 200 cycles each
  initial begin
    #(5 * 200 * 10);
    $display("Watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Bus tasks, handshakes sampled at the falling edge
  // --------------------------------------------------
  task automatic write_reg(input hello_world_pkg::ocl_addr_t addr,
                           input hello_world_pkg::ocl_data_t data, input int bdelay);
    sh_ocl_awvalid = 1'b1;
    sh_ocl_awaddr  = addr;
    do @(negedge clk_main_a0); while (!ocl_sh_awready);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_awvalid = 1'b0;
    sh_ocl_wvalid  = 1'b1;
    sh_ocl_wdata   = data;
    do @(negedge clk_main_a0); while (!ocl_sh_wready);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_wvalid = 1'b0;
    repeat (bdelay) begin
      @(posedge clk_main_a0);
      #1;
    end
    sh_ocl_bready = 1'b1;
    do @(negedge clk_main_a0); while (!ocl_sh_bvalid);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_bready = 1'b0;
  endtask

  task automatic read_reg(input hello_world_pkg::ocl_addr_t addr, input int rdelay);
    sh_ocl_arvalid = 1'b1;
    sh_ocl_araddr  = addr;
    do @(negedge clk_main_a0); while (!ocl_sh_arready);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_arvalid = 1'b0;
    repeat (rdelay) begin
      @(posedge clk_main_a0);
      #1;
    end
    sh_ocl_rready = 1'b1;
    do @(negedge clk_main_a0); while (!ocl_sh_rvalid);
    @(posedge clk_main_a0);
    #1;
    sh_ocl_rready = 1'b0;
  endtask

  task automatic end_test(input string name);
    int unsigned fails_now;
    fails_now = dut_i.assertions_i.fail_count;
    tests_run++;
    if (fails_now > fails_before) begin
      tests_failed++;
      $display("Test %s: %0d assertion failures", name, fails_now - fails_before);
    end else begin
      $display("Test %s: ok", name);
    end
    fails_before = fails_now;
  endtask

  initial begin
    seed = 32'h63a375d3;
    tests_run = 0;
    tests_failed = 0;
    fails_before = 0;
    rst_main_n_sync = 1'b0;
    sh_ocl_awvalid = 1'b0;
    sh_ocl_awaddr = '0;
    sh_ocl_wvalid = 1'b0;
    sh_ocl_wdata = '0;
    sh_ocl_bready = 1'b0;
    sh_ocl_arvalid = 1'b0;
    sh_ocl_araddr = '0;
    sh_ocl_rready = 1'b0;
    sh_cl_status_vdip = '0;
    repeat (2) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    repeat (2) @(posedge clk_main_a0);
    #1;
    end_test("reset_state");

    repeat (4) begin
      write_reg(`HELLO_WORLD_REG_ADDR, $random(seed), 0);
      read_reg(`HELLO_WORLD_REG_ADDR, 0);
    end
    end_test("hello_world_readback");

    // Writes outside the map must leave the register alone
    write_reg(32'h0000_0508, $random(seed), 0);
    read_reg(`VLED_REG_ADDR, 0);
    read_reg(32'h0000_0508, 0);
    read_reg($random(seed), 0);
    read_reg(`HELLO_WORLD_REG_ADDR, 0);
    end_test("vled_and_unknown_address");

    repeat (6) begin
      sh_cl_status_vdip = hello_world_pkg::vled_t'($random(seed));
      write_reg(`HELLO_WORLD_REG_ADDR, $random(seed), 0);
      repeat (5) @(posedge clk_main_a0);
      #1;
    end
    sh_cl_status_vdip = 16'hffff;
    repeat (5) @(posedge clk_main_a0);
    #1;
    end_test("masked_led_output");

    write_reg(`HELLO_WORLD_REG_ADDR, $random(seed), 4);
    read_reg(`HELLO_WORLD_REG_ADDR, 4);
    read_reg(`VLED_REG_ADDR, 3);
    end_test("back_pressure");

    $display("Tests run: %0d, failed: %0d, assertion failures: %0d",
             tests_run, tests_failed, fails_before);
    if (tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verification/cl_hello_world_assertions.sv */
`include "hello_world_defines.svh"

module cl_hello_world_assertions (
  input logic                       clk_main_a0,
  input logic                       rst_main_n_sync,
  input logic                       sh_ocl_awvalid,
  input hello_world_pkg::ocl_addr_t sh_ocl_awaddr,
  input logic                       sh_ocl_wvalid,
  input hello_world_pkg::ocl_data_t sh_ocl_wdata,
  input logic                       sh_ocl_bready,
  input logic                       sh_ocl_arvalid,
  input hello_world_pkg::ocl_addr_t sh_ocl_araddr,
  input logic                       sh_ocl_rready,
  input hello_world_pkg::vled_t     sh_cl_status_vdip,
  input logic                       ocl_sh_awready,
  input logic                       ocl_sh_wready,
  input logic                       ocl_sh_bvalid,
  input logic                       ocl_sh_arready,
  input logic                       ocl_sh_rvalid,
  input hello_world_pkg::ocl_data_t ocl_sh_rdata,
  input hello_world_pkg::vled_t     cl_sh_status_vled
);

  hello_world_pkg::ocl_addr_t aw_addr_q;
  hello_world_pkg::ocl_addr_t ar_addr_q;
  hello_world_pkg::ocl_data_t hw_model;
  hello_world_pkg::ocl_data_t hw_d1;
  hello_world_pkg::ocl_data_t hw_d2;
  hello_world_pkg::ocl_data_t exp_rdata;
  hello_world_pkg::vled_t     exp_vled;
  logic w_hs;
  logic ar_hs;
  logic hw_wr;
  int unsigned fail_count = 0;

  assign w_hs  = sh_ocl_wvalid && ocl_sh_wready;
  assign ar_hs = sh_ocl_arvalid && ocl_sh_arready;
  assign hw_wr = w_hs && (aw_addr_q == `HELLO_WORLD_REG_ADDR);

  // Read value seen by the bus for an address, from the register map rules
  function automatic hello_world_pkg::ocl_data_t expected_read(
    input hello_world_pkg::ocl_addr_t addr,
    input hello_world_pkg::ocl_data_t hw,
    input hello_world_pkg::ocl_data_t hw_old
  );
    if (addr == `HELLO_WORLD_REG_ADDR) begin
      return {hw[7:0], hw[15:8], hw[23:16], hw[31:24]};
    end else if (addr == `VLED_REG_ADDR) begin
      return {16'h0000, hw_old[15:0]};
    end
    return `UNIMPLEMENTED_REG_VALUE;
  endfunction

  // --------------------------------------------------
  // Reference model of the hello-world register
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (sh_ocl_awvalid && ocl_sh_awready) begin
      aw_addr_q <= sh_ocl_awaddr;
    end
    if (ar_hs) begin
      ar_addr_q <= sh_ocl_araddr;
    end
    if (!rst_main_n_sync) begin
      hw_model <= '0;
    end else if (hw_wr) begin
      hw_model <= sh_ocl_wdata;
    end
    hw_d1 <= hw_model;
    hw_d2 <= hw_d1;
  end

  assign exp_rdata = expected_read(ar_addr_q, hw_d1, hw_d2);
  assign exp_vled  = hw_model[15:0] & sh_cl_status_vdip;

  // --------------------------------------------------
  // Properties
  // --------------------------------------------------
  reset_state_a: assert property (@(posedge clk_main_a0)
    (rst_main_n_sync && !$past(rst_main_n_sync)) |->
      (ocl_sh_awready && ocl_sh_arready && !ocl_sh_bvalid && !ocl_sh_rvalid &&
       cl_sh_status_vled == '0))
    else begin
      $error("Outputs after reset are not in their reset state");
      fail_count++;
    end

  bvalid_timing_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    w_hs |=> ocl_sh_bvalid)
    else begin
      $error("bvalid did not rise 1 cycle after the w handshake");
      fail_count++;
    end

  bvalid_cause_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(ocl_sh_bvalid) |-> $past(w_hs))
    else begin
      $error("bvalid rose without a w handshake in the previous cycle");
      fail_count++;
    end

  rvalid_timing_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ar_hs |=> !ocl_sh_rvalid ##1 ocl_sh_rvalid)
    else begin
      $error("rvalid did not rise exactly 2 cycles after the ar handshake");
      fail_count++;
    end

  rdata_value_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(ocl_sh_rvalid) |-> (ocl_sh_rdata == exp_rdata))
    else begin
      $error("ERROR %0t ocl_sh_rdata got %h expected %h", $time,
             $sampled(ocl_sh_rdata), $sampled(exp_rdata));
      fail_count++;
    end

  // DIP stable for 3 cycles and no hello-world write in the last 2
  vled_value_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ($past(rst_main_n_sync, 3) && $stable(sh_cl_status_vdip) &&
     $past($stable(sh_cl_status_vdip)) && $past($stable(sh_cl_status_vdip), 2) &&
     !$past(hw_wr) && !$past(hw_wr, 2)) |-> (cl_sh_status_vled == exp_vled))
    else begin
      $error("ERROR %0t cl_sh_status_vled got %h expected %h", $time,
             $sampled(cl_sh_status_vled), $sampled(exp_vled));
      fail_count++;
    end

  r_hold_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (ocl_sh_rvalid && !sh_ocl_rready) |=> (ocl_sh_rvalid && $stable(ocl_sh_rdata)))
    else begin
      $error("rvalid or rdata changed while rready was low");
      fail_count++;
    end

  b_hold_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (ocl_sh_bvalid && !sh_ocl_bready) |=> ocl_sh_bvalid)
    else begin
      $error("bvalid dropped while bready was low");
      fail_count++;
    end

  busy_ready_a: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (!(ocl_sh_rvalid && ocl_sh_arready)) &&
    (!(ocl_sh_bvalid && (ocl_sh_awready || ocl_sh_wready))))
    else begin
      $error("A ready was high while a response was pending");
      fail_count++;
    end

endmodule

bind cl_hello_world cl_hello_world_assertions assertions_i (.*);

/* hdl/cl_hello_world.sv */
`include "hello_world_defines.svh"

module cl_hello_world (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  logic                       sh_ocl_awvalid,
  input  hello_world_pkg::ocl_addr_t sh_ocl_awaddr,
  input  logic                       sh_ocl_wvalid,
  input  hello_world_pkg::ocl_data_t sh_ocl_wdata,
  input  logic                       sh_ocl_bready,
  input  logic                       sh_ocl_arvalid,
  input  hello_world_pkg::ocl_addr_t sh_ocl_araddr,
  input  logic                       sh_ocl_rready,
  input  hello_world_pkg::vled_t     sh_cl_status_vdip,
  output logic                       ocl_sh_awready,
  output logic                       ocl_sh_wready,
  output logic                       ocl_sh_bvalid,
  output logic                       ocl_sh_arready,
  output logic                       ocl_sh_rvalid,
  output hello_world_pkg::ocl_data_t ocl_sh_rdata,
  output hello_world_pkg::vled_t     cl_sh_status_vled
);

  hello_world_pkg::vled_t vled;

  reg_access_if reg_if ();

  // --------------------------------------------------
  // OCL AXI-Lite slave
  // --------------------------------------------------
  ocl_slave ocl_slave_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .sh_ocl_awvalid  (sh_ocl_awvalid),
    .sh_ocl_awaddr   (sh_ocl_awaddr),
    .sh_ocl_wvalid   (sh_ocl_wvalid),
    .sh_ocl_wdata    (sh_ocl_wdata),
    .sh_ocl_bready   (sh_ocl_bready),
    .sh_ocl_arvalid  (sh_ocl_arvalid),
    .sh_ocl_araddr   (sh_ocl_araddr),
    .sh_ocl_rready   (sh_ocl_rready),
    .ocl_sh_awready  (ocl_sh_awready),
    .ocl_sh_wready   (ocl_sh_wready),
    .ocl_sh_bvalid   (ocl_sh_bvalid),
    .ocl_sh_arready  (ocl_sh_arready),
    .ocl_sh_rvalid   (ocl_sh_rvalid),
    .ocl_sh_rdata    (ocl_sh_rdata),
    .reg_if          (reg_if.bus)
  );

  // Register bank
  hello_regs hello_regs_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_if          (reg_if.regs),
    .vled            (vled)
  );

  // LED output stage
  vled_output vled_output_i (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .vled              (vled),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

endmodule

/* hdl/vled_output.sv */
`include "hello_world_defines.svh"

module vled_output (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  input  hello_world_pkg::vled_t vled,
  input  hello_world_pkg::vled_t sh_cl_status_vdip,
  output hello_world_pkg::vled_t cl_sh_status_vled
);

  hello_world_pkg::vled_t vdip_q;
  hello_world_pkg::vled_t vdip_q2;

  // --------------------------------------------------
  // DIP synchronizer and masked LED flop
  // --------------------------------------------------
  // Two stages before the DIP value is used
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= sh_cl_status_vdip;
      vdip_q2 <= vdip_q;
    end
  end

  // A switch that is off blanks its LED
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cl_sh_status_vled <= '0;
    end else begin
      cl_sh_status_vled <= vled & vdip_q2;
    end
  end

endmodule

/* hdl/hello_regs.sv */
`include "hello_world_defines.svh"

module hello_regs (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  reg_access_if.regs             reg_if,
  output hello_world_pkg::vled_t vled
);

  hello_world_pkg::ocl_data_t hello_world_q;
  hello_world_pkg::ocl_data_t hello_world_swapped;
  hello_world_pkg::vled_t     vled_q;

  // --------------------------------------------------
  // Hello-world register
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
    end else if (reg_if.wr_en && (reg_if.wr_addr == `HELLO_WORLD_REG_ADDR)) begin
      hello_world_q <= reg_if.wr_data;
    end
  end

  // Reads return the bytes in reverse order
  assign hello_world_swapped = {hello_world_q[7:0],
                                hello_world_q[15:8],
                                hello_world_q[23:16],
                                hello_world_q[31:24]};

  // --------------------------------------------------
  // Virtual LED shadow
  // --------------------------------------------------
  // Follows the low half one cycle behind
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_world_q[`VLED_W-1:0];
    end
  end

  assign vled = vled_q;

  // Read mux
  always_comb begin
    case (reg_if.rd_addr)
      `HELLO_WORLD_REG_ADDR: reg_if.rd_data = hello_world_swapped;
      `VLED_REG_ADDR:        reg_if.rd_data = {{(`OCL_DATA_W-`VLED_W){1'b0}}, vled_q};
      default:               reg_if.rd_data = `UNIMPLEMENTED_REG_VALUE;
    endcase
  end

endmodule

/* hdl/ocl_slave.sv */
`include "hello_world_defines.svh"

module ocl_slave (
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  logic                       sh_ocl_awvalid,
  input  hello_world_pkg::ocl_addr_t sh_ocl_awaddr,
  input  logic                       sh_ocl_wvalid,
  input  hello_world_pkg::ocl_data_t sh_ocl_wdata,
  input  logic                       sh_ocl_bready,
  input  logic                       sh_ocl_arvalid,
  input  hello_world_pkg::ocl_addr_t sh_ocl_araddr,
  input  logic                       sh_ocl_rready,
  output logic                       ocl_sh_awready,
  output logic                       ocl_sh_wready,
  output logic                       ocl_sh_bvalid,
  output logic                       ocl_sh_arready,
  output logic                       ocl_sh_rvalid,
  output hello_world_pkg::ocl_data_t ocl_sh_rdata,
  reg_access_if.bus                  reg_if
);

  hello_world_pkg::wr_state_t wr_state;
  hello_world_pkg::rd_state_t rd_state;
  hello_world_pkg::ocl_addr_t wr_addr_q;
  hello_world_pkg::ocl_addr_t rd_addr_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  assign ocl_sh_awready = (wr_state == hello_world_pkg::wr_idle);
  // wready only while a data beat is owed for the captured address
  assign ocl_sh_wready  = (wr_state == hello_world_pkg::wr_data) && sh_ocl_wvalid;
  assign ocl_sh_bvalid  = (wr_state == hello_world_pkg::wr_resp);

  assign aw_hs = sh_ocl_awvalid && ocl_sh_awready;
  assign w_hs  = sh_ocl_wvalid && ocl_sh_wready;
  assign b_hs  = ocl_sh_bvalid && sh_ocl_bready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= hello_world_pkg::wr_idle;
    end else begin
      case (wr_state)
        hello_world_pkg::wr_idle: begin
          if (aw_hs) begin
            wr_state <= hello_world_pkg::wr_data;
          end
        end
        hello_world_pkg::wr_data: begin
          if (w_hs) begin
            wr_state <= hello_world_pkg::wr_resp;
          end
        end
        hello_world_pkg::wr_resp: begin
          if (b_hs) begin
            wr_state <= hello_world_pkg::wr_idle;
          end
        end
        default: wr_state <= hello_world_pkg::wr_idle;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_addr_q <= '0;
    end else if (aw_hs) begin
      wr_addr_q <= sh_ocl_awaddr;
    end
  end

  // Register bank write happens on the w handshake edge
  assign reg_if.wr_en   = w_hs;
  assign reg_if.wr_addr = wr_addr_q;
  assign reg_if.wr_data = sh_ocl_wdata;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  assign ocl_sh_arready = (rd_state == hello_world_pkg::rd_idle);
  assign ocl_sh_rvalid  = (rd_state == hello_world_pkg::rd_resp);

  assign ar_hs = sh_ocl_arvalid && ocl_sh_arready;
  assign r_hs  = ocl_sh_rvalid && sh_ocl_rready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state     <= hello_world_pkg::rd_idle;
      ocl_sh_rdata <= '0;
    end else begin
      case (rd_state)
        hello_world_pkg::rd_idle: begin
          if (ar_hs) begin
            rd_state <= hello_world_pkg::rd_lookup;
          end
        end
        // One cycle for the register bank to decode the address
        hello_world_pkg::rd_lookup: begin
          ocl_sh_rdata <= reg_if.rd_data;
          rd_state     <= hello_world_pkg::rd_resp;
        end
        hello_world_pkg::rd_resp: begin
          if (r_hs) begin
            rd_state <= hello_world_pkg::rd_idle;
          end
        end
        default: rd_state <= hello_world_pkg::rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_addr_q <= '0;
    end else if (ar_hs) begin
      rd_addr_q <= sh_ocl_araddr;
    end
  end

  assign reg_if.rd_addr = rd_addr_q;

endmodule

/* hdl/reg_access_if.sv */
`include "hello_world_defines.svh"

interface reg_access_if;

  // Write port, wr_en is a single-cycle strobe
  logic                       wr_en;
  hello_world_pkg::ocl_addr_t wr_addr;
  hello_world_pkg::ocl_data_t wr_data;

  // Read port, data is selected combinationally from the address
  hello_world_pkg::ocl_addr_t rd_addr;
  hello_world_pkg::ocl_data_t rd_data;

  modport bus (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_addr,
    input  rd_data
  );

  modport regs (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

/* hdl/hello_world_pkg.sv */
`include "hello_world_defines.svh"

package hello_world_pkg;

  // Bus payload words
  typedef logic [`OCL_ADDR_W-1:0] ocl_addr_t;
  typedef logic [`OCL_DATA_W-1:0] ocl_data_t;

  // One bit per virtual LED or DIP switch
  typedef logic [`VLED_W-1:0] vled_t;

  // Write channel sequencing
  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_t;

  // Read channel sequencing
  typedef enum logic [1:0] {
    rd_idle,
    rd_lookup,
    rd_resp
  } rd_state_t;

endpackage

/* hdl/hello_world_defines.svh */
`ifndef HELLO_WORLD_DEFINES_SVH
`define HELLO_WORLD_DEFINES_SVH

// --------------------------------------------------
// Bus and LED widths
// --------------------------------------------------
`define OCL_ADDR_W 32
`define OCL_DATA_W 32
`define VLED_W 16

// --------------------------------------------------
// Register map
// --------------------------------------------------
`define HELLO_WORLD_REG_ADDR 32'h0000_0500
`define VLED_REG_ADDR 32'h0000_0504

// Returned for any address outside the map
`define UNIMPLEMENTED_REG_VALUE 32'hdead_dead

`endif
